//--- wb_defs.svh
// --------------------
// Writeback stage widths
// Result word, register index, buffer depth and
// the pointer width shared by both result buffers
// --------------------

`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Result payload
`define WB_DATA_W     32
`define WB_REG_W      5

// Buffer geometry, depth need not be a power of two
`define WB_BUF_DEPTH  31
`define WB_PTR_W      5               // Must hold WB_BUF_DEPTH itself

// Values loaded at reset
`define WB_PTR_RST    {`WB_PTR_W{1'b0}}
`define WB_TURN_RST   1'b0            // 0 gives the load buffer the first turn

`endif

//--- wb_pkg.sv
// --------------------
// Writeback package
// Buffer entry layout and speculation states
// --------------------

`default_nettype none

`include "wb_defs.svh"

package wb_pkg;

    // One stored result, index in the upper bits
    typedef struct packed {
        logic [`WB_REG_W-1:0]  reg_sel;     // Destination register
        logic [`WB_DATA_W-1:0] wdat;        // Result word
    } wb_entry_t;

    // Branch speculation tracker
    typedef enum logic {
        IDLE = 1'b0,                        // No open branch
        SPEC = 1'b1                         // ALU results behind a branch
    } spec_state_t;

endpackage

`default_nettype wire

//--- wb_buffers.sv
// --------------------
// Writeback result buffers
// Circular ALU buffer with write-pointer rollback
// and a plain circular load buffer, both drained
// in arrival order
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_buffers import wb_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    // ALU side
    input  logic                 alu_push,
    input  logic                 alu_pop,
    input  wb_entry_t            alu_din,
    // Load side
    input  logic                 load_push,
    input  logic                 load_pop,
    input  wb_entry_t            load_din,
    // Rollback from the speculation tracker
    input  logic                 squash,
    input  logic [`WB_PTR_W-1:0] squash_wptr,
    input  logic [`WB_PTR_W-1:0] squash_drop,
    // Oldest entries and status
    output wb_entry_t            alu_head,
    output wb_entry_t            load_head,
    output logic                 alu_empty,
    output logic                 load_empty,
    output logic [`WB_PTR_W-1:0] alu_count,
    output logic [`WB_PTR_W-1:0] alu_wptr
);

    // Storage, no reset needed on the data
    wb_entry_t alu_mem  [`WB_BUF_DEPTH];
    wb_entry_t load_mem [`WB_BUF_DEPTH];

    logic [`WB_PTR_W-1:0] alu_rptr;
    logic [`WB_PTR_W-1:0] load_rptr;
    logic [`WB_PTR_W-1:0] load_wptr;
    logic [`WB_PTR_W-1:0] load_count;

    logic [`WB_PTR_W-1:0] alu_wbase;        // Write slot after any rollback
    logic [`WB_PTR_W-1:0] alu_cbase;        // Count after any rollback

    // Explicit wrap, depth is not a power of two
    function automatic logic [`WB_PTR_W-1:0] ptr_inc(input logic [`WB_PTR_W-1:0] p);
        if (p == `WB_PTR_W'(`WB_BUF_DEPTH - 1)) begin
            ptr_inc = '0;
        end else begin
            ptr_inc = p + 1'b1;
        end
    endfunction

    // Squash rewinds to the branch point before this cycle's push
    assign alu_wbase = squash ? squash_wptr : alu_wptr;
    assign alu_cbase = squash ? (alu_count - squash_drop) : alu_count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_wptr   <= `WB_PTR_RST;
            alu_rptr   <= `WB_PTR_RST;
            alu_count  <= `WB_PTR_RST;
            load_wptr  <= `WB_PTR_RST;
            load_rptr  <= `WB_PTR_RST;
            load_count <= `WB_PTR_RST;
        end else begin
            // ALU pointers
            alu_wptr <= alu_push ? ptr_inc(alu_wbase) : alu_wbase;
            if (alu_pop) begin
                alu_rptr <= ptr_inc(alu_rptr);  // Only clean entries leave, never squashed ones
            end
            case ({alu_push, alu_pop})
                2'b10:   alu_count <= alu_cbase + 1'b1;
                2'b01:   alu_count <= alu_cbase - 1'b1;
                default: alu_count <= alu_cbase;    // Idle, or push and pop cancel
            endcase

            // Load pointers
            if (load_push) begin
                load_wptr <= ptr_inc(load_wptr);
            end
            if (load_pop) begin
                load_rptr <= ptr_inc(load_rptr);
            end
            case ({load_push, load_pop})
                2'b10:   load_count <= load_count + 1'b1;
                2'b01:   load_count <= load_count - 1'b1;
                default: load_count <= load_count;
            endcase
        end
    end

    // Entry writes
    always_ff @(posedge CLK) begin
        if (alu_push) begin
            alu_mem[alu_wbase] <= alu_din;          // Lands on the restored slot after a squash
        end
        if (load_push) begin
            load_mem[load_wptr] <= load_din;
        end
    end

    // Oldest entries, valid only when not empty
    assign alu_head  = alu_mem[alu_rptr];
    assign load_head = load_mem[load_rptr];

    assign alu_empty  = (alu_count == '0);
    assign load_empty = (load_count == '0);

endmodule

`default_nettype wire

//--- wb_spec_ctrl.sv
// --------------------
// Speculation tracker
// Follows one open branch, keeps the ALU write
// pointer snapshot and counts clean and speculative
// ALU entries, requests rollback on a mispredict
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_spec_ctrl import wb_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    // Branch unit
    input  logic                 branch_spec,        // Level
    input  logic                 branch_correct,     // Pulse
    input  logic                 branch_mispredict,  // Pulse
    // ALU buffer activity
    input  logic                 alu_push,
    input  logic                 alu_pop,
    input  logic [`WB_PTR_W-1:0] alu_count,
    input  logic [`WB_PTR_W-1:0] alu_wptr,
    // To the arbiter
    output logic                 spec_active,
    output logic                 alu_clean,
    // To the ALU buffer
    output logic                 squash,
    output logic [`WB_PTR_W-1:0] squash_wptr,
    output logic [`WB_PTR_W-1:0] squash_drop
);

    spec_state_t          state;
    logic                 prev_spec;          // branch_spec one cycle back
    logic [`WB_PTR_W-1:0] saved_wptr;         // First speculative slot
    logic [`WB_PTR_W-1:0] spec_cnt;           // ALU entries behind the branch
    logic [`WB_PTR_W-1:0] clean_cnt;          // Older ALU entries still buffered

    logic spec_open;
    logic resolve;

    // Rising edge of branch_spec opens speculation
    assign spec_open = (state == IDLE) && branch_spec && !prev_spec;
    assign resolve   = (state == SPEC) && (branch_correct || branch_mispredict);

    assign spec_active = spec_open || (state == SPEC);
    assign alu_clean   = (state == IDLE) || (clean_cnt != '0);  // Opening cycle still all clean

    // Rollback request, applied by the buffer on this edge
    assign squash      = (state == SPEC) && branch_mispredict;
    assign squash_wptr = saved_wptr;
    assign squash_drop = spec_cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            prev_spec  <= 1'b0;
            saved_wptr <= `WB_PTR_RST;
            spec_cnt   <= `WB_PTR_RST;
            clean_cnt  <= `WB_PTR_RST;
        end else begin
            prev_spec <= branch_spec;
            if (spec_open) begin
                state      <= SPEC;
                saved_wptr <= alu_wptr;                           // A push now is speculative
                spec_cnt   <= alu_push ? `WB_PTR_W'(1) : '0;
                clean_cnt  <= alu_pop ? (alu_count - 1'b1) : alu_count;
            end else if (resolve) begin
                // Either outcome ends speculation; a push here is ordinary
                state     <= IDLE;
                spec_cnt  <= '0;
                clean_cnt <= '0;
            end else if (state == SPEC) begin
                if (alu_push) begin
                    spec_cnt <= spec_cnt + 1'b1;
                end
                if (alu_pop) begin
                    clean_cnt <= clean_cnt - 1'b1;    // Arbiter pops only while above zero
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- wb_arbiter.sv
// --------------------
// Writeback port arbiter
// Picks the result for the register-file port each
// cycle, bypasses when possible, otherwise buffers
// and drains the two buffers in turn
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_arbiter import wb_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    // Producers
    input  logic                  alu_done,
    input  logic [`WB_REG_W-1:0]  alu_reg_sel,
    input  logic [`WB_DATA_W-1:0] alu_wdat,
    input  logic                  load_done,
    input  logic [`WB_REG_W-1:0]  load_reg_sel,
    input  logic [`WB_DATA_W-1:0] load_wdat,
    input  logic                  jump_done,
    input  logic [`WB_REG_W-1:0]  jump_reg_sel,
    input  logic [`WB_DATA_W-1:0] jump_wdat,
    // Buffer state
    input  wb_entry_t             alu_head,
    input  wb_entry_t             load_head,
    input  logic                  alu_empty,
    input  logic                  load_empty,
    // Speculation tracker
    input  logic                  spec_active,
    input  logic                  alu_clean,
    // Register-file write port
    output logic                  wb_reg_en,
    output logic [`WB_REG_W-1:0]  wb_reg_sel,
    output logic [`WB_DATA_W-1:0] wb_wdat,
    // Buffer control
    output logic                  alu_push,
    output logic                  load_push,
    output logic                  alu_pop,
    output logic                  load_pop
);

    logic      alu_turn;       // 1 when the ALU buffer wins the next tie
    logic      turn_flip;
    logic      both_empty;
    logic      alu_can;        // ALU buffer may drain this cycle
    logic      load_can;
    wb_entry_t wb_out;

    assign both_empty = alu_empty && load_empty;
    assign alu_can    = !alu_empty && alu_clean;   // Speculative entries stay put
    assign load_can   = !load_empty;

    always_comb begin
        wb_reg_en = 1'b0;
        wb_out    = '0;
        alu_push  = 1'b0;
        load_push = 1'b0;
        alu_pop   = 1'b0;
        load_pop  = 1'b0;
        turn_flip = 1'b0;

        if (jump_done) begin
            // Jump owns the port, everything else waits in the buffers
            wb_reg_en = 1'b1;
            wb_out    = {jump_reg_sel, jump_wdat};
            alu_push  = alu_done;
            load_push = load_done;
        end else if (both_empty && load_done) begin
            wb_reg_en = 1'b1;                          // Load bypass
            wb_out    = {load_reg_sel, load_wdat};
            alu_push  = alu_done;
        end else if (both_empty && alu_done && !spec_active) begin
            wb_reg_en = 1'b1;                          // ALU bypass
            wb_out    = {alu_reg_sel, alu_wdat};
        end else begin
            // New results queue behind older ones
            alu_push  = alu_done;
            load_push = load_done;
            if (alu_can && load_can) begin
                turn_flip = 1'b1;
                if (alu_turn) begin
                    alu_pop = 1'b1;
                    wb_out  = alu_head;
                end else begin
                    load_pop = 1'b1;
                    wb_out   = load_head;
                end
                wb_reg_en = 1'b1;
            end else if (alu_can) begin
                alu_pop   = 1'b1;
                wb_reg_en = 1'b1;
                wb_out    = alu_head;
            end else if (load_can) begin
                load_pop  = 1'b1;
                wb_reg_en = 1'b1;
                wb_out    = load_head;
            end
        end
    end

    assign wb_reg_sel = wb_out.reg_sel;
    assign wb_wdat    = wb_out.wdat;

    // Turn bit, only moves when both buffers competed
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_turn <= `WB_TURN_RST;
        end else if (turn_flip) begin
            alu_turn <= !alu_turn;
        end
    end

endmodule

`default_nettype wire

//--- writeback.sv
// --------------------
// Writeback stage top
// Arbiter, result buffers and speculation tracker
// behind the register-file write port
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module writeback import wb_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    // ALU result
    input  logic                  alu_done,
    input  logic [`WB_REG_W-1:0]  alu_reg_sel,
    input  logic [`WB_DATA_W-1:0] alu_wdat,
    // Load result
    input  logic                  load_done,
    input  logic [`WB_REG_W-1:0]  load_reg_sel,
    input  logic [`WB_DATA_W-1:0] load_wdat,
    // Jump result
    input  logic                  jump_done,
    input  logic [`WB_REG_W-1:0]  jump_reg_sel,
    input  logic [`WB_DATA_W-1:0] jump_wdat,
    // Branch unit
    input  logic                  branch_spec,
    input  logic                  branch_correct,
    input  logic                  branch_mispredict,
    // Register-file write port
    output logic                  wb_reg_en,
    output logic [`WB_REG_W-1:0]  wb_reg_sel,
    output logic [`WB_DATA_W-1:0] wb_wdat
);

    // Arbiter to buffers
    logic                 alu_push;
    logic                 load_push;
    logic                 alu_pop;
    logic                 load_pop;

    // Buffer status
    wb_entry_t            alu_head;
    wb_entry_t            load_head;
    logic                 alu_empty;
    logic                 load_empty;
    logic [`WB_PTR_W-1:0] alu_count;
    logic [`WB_PTR_W-1:0] alu_wptr;

    // Speculation tracker outputs
    logic                 spec_active;
    logic                 alu_clean;
    logic                 squash;
    logic [`WB_PTR_W-1:0] squash_wptr;
    logic [`WB_PTR_W-1:0] squash_drop;

    wb_arbiter u_arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .alu_done     (alu_done),
        .alu_reg_sel  (alu_reg_sel),
        .alu_wdat     (alu_wdat),
        .load_done    (load_done),
        .load_reg_sel (load_reg_sel),
        .load_wdat    (load_wdat),
        .jump_done    (jump_done),
        .jump_reg_sel (jump_reg_sel),
        .jump_wdat    (jump_wdat),
        .alu_head     (alu_head),
        .load_head    (load_head),
        .alu_empty    (alu_empty),
        .load_empty   (load_empty),
        .spec_active  (spec_active),
        .alu_clean    (alu_clean),
        .wb_reg_en    (wb_reg_en),
        .wb_reg_sel   (wb_reg_sel),
        .wb_wdat      (wb_wdat),
        .alu_push     (alu_push),
        .load_push    (load_push),
        .alu_pop      (alu_pop),
        .load_pop     (load_pop)
    );

    // Entries are packed index first, matching wb_entry_t
    wb_buffers u_buffers (
        .CLK         (CLK),
        .nRST        (nRST),
        .alu_push    (alu_push),
        .alu_pop     (alu_pop),
        .alu_din     ({alu_reg_sel, alu_wdat}),
        .load_push   (load_push),
        .load_pop    (load_pop),
        .load_din    ({load_reg_sel, load_wdat}),
        .squash      (squash),
        .squash_wptr (squash_wptr),
        .squash_drop (squash_drop),
        .alu_head    (alu_head),
        .load_head   (load_head),
        .alu_empty   (alu_empty),
        .load_empty  (load_empty),
        .alu_count   (alu_count),
        .alu_wptr    (alu_wptr)
    );

    wb_spec_ctrl u_spec_ctrl (
        .CLK               (CLK),
        .nRST              (nRST),
        .branch_spec       (branch_spec),
        .branch_correct    (branch_correct),
        .branch_mispredict (branch_mispredict),
        .alu_push          (alu_push),
        .alu_pop           (alu_pop),
        .alu_count         (alu_count),
        .alu_wptr          (alu_wptr),
        .spec_active       (spec_active),
        .alu_clean         (alu_clean),
        .squash            (squash),
        .squash_wptr       (squash_wptr),
        .squash_drop       (squash_drop)
    );

endmodule

`default_nettype wire

//--- writeback_chk.sv
// --------------------
// Writeback stage checker
// Concurrent assertions on reset, buffer
// occupancy and speculative draining
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module writeback_chk import wb_pkg::*; (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 wb_reg_en,
    input logic [`WB_PTR_W-1:0] alu_count,
    input logic [`WB_PTR_W-1:0] load_count,
    input logic                 alu_push,
    input logic                 alu_pop,
    input logic                 load_push,
    input logic                 load_pop,
    input logic                 squash,
    input logic [`WB_PTR_W-1:0] squash_drop,
    input spec_state_t          state,
    input logic [`WB_PTR_W-1:0] alu_rptr,
    input logic [`WB_PTR_W-1:0] saved_wptr
);

    localparam logic [`WB_PTR_W-1:0] DEPTH_CNT = `WB_PTR_W'(`WB_BUF_DEPTH);

    // Port stays quiet in reset
    a_reset_quiet: assert property (@(posedge CLK) !nRST |-> !wb_reg_en)
        else $error("wb_reg_en high during reset");

    // A full buffer takes a push only when an entry leaves on the same edge
    a_alu_depth: assert property (@(posedge CLK) disable iff (!nRST)
        (alu_count == DEPTH_CNT && alu_push) |->
            (alu_pop || (squash && squash_drop != '0)))
        else $error("ALU buffer count above depth");

    a_load_depth: assert property (@(posedge CLK) disable iff (!nRST)
        (load_count == DEPTH_CNT && load_push) |-> load_pop)
        else $error("Load buffer count above depth");

    // Head at the branch point is speculative unless the buffer wrapped full
    a_spec_pop: assert property (@(posedge CLK) disable iff (!nRST)
        (state == SPEC && alu_pop) |-> (alu_rptr != saved_wptr || alu_count == DEPTH_CNT))
        else $error("ALU pop of a speculative entry");

endmodule

bind writeback writeback_chk u_chk (
    .CLK         (CLK),
    .nRST        (nRST),
    .wb_reg_en   (wb_reg_en),
    .alu_count   (alu_count),
    .load_count  (u_buffers.load_count),
    .alu_push    (alu_push),
    .alu_pop     (alu_pop),
    .load_push   (load_push),
    .load_pop    (load_pop),
    .squash      (squash),
    .squash_drop (squash_drop),
    .state       (u_spec_ctrl.state),
    .alu_rptr    (u_buffers.alu_rptr),
    .saved_wptr  (u_spec_ctrl.saved_wptr)
);

`default_nettype wire

//--- writeback_tb.sv
// --------------------
// Writeback stage testbench
// Replays per-cycle vectors from the stim file
// and compares the register-file write port
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module writeback_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;
    localparam int MAX_VEC    = 64;
    localparam int N_COLS     = 15;

    logic                  CLK;
    logic                  nRST;
    logic                  alu_done;
    logic [`WB_REG_W-1:0]  alu_reg_sel;
    logic [`WB_DATA_W-1:0] alu_wdat;
    logic                  load_done;
    logic [`WB_REG_W-1:0]  load_reg_sel;
    logic [`WB_DATA_W-1:0] load_wdat;
    logic                  jump_done;
    logic [`WB_REG_W-1:0]  jump_reg_sel;
    logic [`WB_DATA_W-1:0] jump_wdat;
    logic                  branch_spec;
    logic                  branch_correct;
    logic                  branch_mispredict;
    logic                  wb_reg_en;
    logic [`WB_REG_W-1:0]  wb_reg_sel;
    logic [`WB_DATA_W-1:0] wb_wdat;

    // One row per cycle, columns as in the stim file
    logic [31:0] stim [0:MAX_VEC-1][0:N_COLS-1];
    int          n_vec;
    int          n_checks;
    int          n_errors;
    logic        vectors_ready;

    writeback UUT (
        .CLK               (CLK),
        .nRST              (nRST),
        .alu_done          (alu_done),
        .alu_reg_sel       (alu_reg_sel),
        .alu_wdat          (alu_wdat),
        .load_done         (load_done),
        .load_reg_sel      (load_reg_sel),
        .load_wdat         (load_wdat),
        .jump_done         (jump_done),
        .jump_reg_sel      (jump_reg_sel),
        .jump_wdat         (jump_wdat),
        .branch_spec       (branch_spec),
        .branch_correct    (branch_correct),
        .branch_mispredict (branch_mispredict),
        .wb_reg_en         (wb_reg_en),
        .wb_reg_sel        (wb_reg_sel),
        .wb_wdat           (wb_wdat)
    );

    always #(CLK_PERIOD / 2) CLK = !CLK;

    // Lines that do not hold all columns are comments
    task automatic read_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [0:N_COLS-1];
        fd = $fopen("writeback_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file writeback_stim.txt");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                   f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (code == N_COLS) begin
                        for (int c = 0; c < N_COLS; c++) begin
                            stim[n_vec][c] = f[c];
                        end
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs change right after the rising edge
    task automatic drive_vector(input int i);
        alu_done          <= stim[i][0][0];
        alu_reg_sel       <= stim[i][1][`WB_REG_W-1:0];
        alu_wdat          <= stim[i][2];
        load_done         <= stim[i][3][0];
        load_reg_sel      <= stim[i][4][`WB_REG_W-1:0];
        load_wdat         <= stim[i][5];
        jump_done         <= stim[i][6][0];
        jump_reg_sel      <= stim[i][7][`WB_REG_W-1:0];
        jump_wdat         <= stim[i][8];
        branch_spec       <= stim[i][9][0];
        branch_correct    <= stim[i][10][0];
        branch_mispredict <= stim[i][11][0];
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error at %t: %s expected %h, got %h", $realtime, name, exp, act);
        n_errors++;
    endtask

    initial begin : main
        $timeformat(-9, 0, " ns", 0);
        CLK               = 1'b0;
        nRST              = 1'b0;      // Held for RST_CYCLES edges
        alu_done          = 1'b0;
        alu_reg_sel       = '0;
        alu_wdat          = '0;
        load_done         = 1'b0;
        load_reg_sel      = '0;
        load_wdat         = '0;
        jump_done         = 1'b0;
        jump_reg_sel      = '0;
        jump_wdat         = '0;
        branch_spec       = 1'b0;
        branch_correct    = 1'b0;
        branch_mispredict = 1'b0;
        n_vec             = 0;
        n_checks          = 0;
        n_errors          = 0;
        vectors_ready     = 1'b0;

        read_vectors();
        vectors_ready = 1'b1;

        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        for (int i = 0; i < n_vec; i++) begin
            @(posedge CLK);
            drive_vector(i);
            @(negedge CLK);                              // Port is settled mid-cycle
            n_checks++;
            if (wb_reg_en !== stim[i][12][0]) begin
                report_mismatch("wb_reg_en", stim[i][12], 32'(wb_reg_en));
            end
            // Index and data only matter when the port writes
            if (stim[i][12][0] && wb_reg_sel !== stim[i][13][`WB_REG_W-1:0]) begin
                report_mismatch("wb_reg_sel", stim[i][13], 32'(wb_reg_sel));
            end
            if (stim[i][12][0] && wb_wdat !== stim[i][14]) begin
                report_mismatch("wb_wdat", stim[i][14], wb_wdat);
            end
        end

        @(posedge CLK);
        if (n_vec == 0) begin
            $display("No stimulus vectors were read, nothing was tested");
        end
        $display("Vectors: %0d, checks: %0d, errors: %0d", n_vec, n_checks, n_errors);
        if (n_vec == 0 || n_errors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

    // Reset, every vector, plus slack
    initial begin : watchdog
        wait (vectors_ready);
        #((RST_CYCLES + n_vec + 20) * CLK_PERIOD);
        $display("Timeout: the run went past the expected number of cycles");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- writeback_stim.txt
# alu_done alu_reg alu_wdat load_done load_reg load_wdat jump_done jump_reg jump_wdat
# branch_spec branch_correct branch_mispredict exp_en exp_reg exp_wdat (all hex, one cycle per line)
# Bypass of lone ALU, load and jump results
1 01 a0000001 0 00 00000000 0 00 00000000 0 0 0 1 01 a0000001
0 00 00000000 1 02 b0000002 0 00 00000000 0 0 0 1 02 b0000002
0 00 00000000 0 00 00000000 1 03 c0000003 0 0 0 1 03 c0000003
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 0 00 00000000
# Load and ALU together, ALU follows in the idle cycle
1 04 a0000004 1 05 b0000005 0 00 00000000 0 0 0 1 05 b0000005
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 04 a0000004
# Fill both buffers, then drain in turns with load first
1 06 a0000006 1 07 b0000007 0 00 00000000 0 0 0 1 07 b0000007
1 08 a0000008 1 09 b0000009 0 00 00000000 0 0 0 1 06 a0000006
1 0a a000000a 1 0b b000000b 0 00 00000000 0 0 0 1 09 b0000009
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 08 a0000008
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 0b b000000b
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 0a a000000a
# Jump takes the port while the buffers hold data
1 0c a000000c 1 0d b000000d 0 00 00000000 0 0 0 1 0d b000000d
0 00 00000000 1 0f b000000f 1 0e c000000e 0 0 0 1 0e c000000e
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 0c a000000c
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 0f b000000f
# Mispredict discards ALU results behind the branch
1 10 a0000010 1 11 b0000011 0 00 00000000 0 0 0 1 11 b0000011
1 12 a0000012 1 13 b0000013 0 00 00000000 0 0 0 1 10 a0000010
1 14 a0000014 0 00 00000000 0 00 00000000 1 0 0 1 13 b0000013
1 15 a0000015 1 16 b0000016 0 00 00000000 1 0 0 1 12 a0000012
0 00 00000000 0 00 00000000 0 00 00000000 1 0 0 1 16 b0000016
0 00 00000000 0 00 00000000 0 00 00000000 1 0 0 0 00 00000000
1 17 a0000017 0 00 00000000 0 00 00000000 1 0 1 0 00 00000000
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 17 a0000017
# Correct branch releases the held ALU results in order
1 18 a0000018 0 00 00000000 0 00 00000000 1 0 0 0 00 00000000
1 19 a0000019 0 00 00000000 0 00 00000000 1 0 0 0 00 00000000
0 00 00000000 0 00 00000000 0 00 00000000 1 1 0 0 00 00000000
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 18 a0000018
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 1 19 a0000019
0 00 00000000 0 00 00000000 0 00 00000000 0 0 0 0 00 00000000

//--- writeback.f
+incdir+.
wb_pkg.sv
wb_buffers.sv
wb_spec_ctrl.sv
wb_arbiter.sv
writeback.sv
writeback_chk.sv
writeback_tb.sv

//--- Makefile
TOP = writeback_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f writeback.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f writeback.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
